//--- compile.f
+incdir+verif
verilog/dnc_pkg.sv
verilog/dnc_write_loader.sv
verilog/dnc_row_update.sv
verilog/dnc_memory_drain.sv
verilog/dnc_memory_matrix.sv
verif/dnc_memory_matrix_tb.sv

//--- Bender.yml
package:
  name: dnc_memory_matrix

sources:
  - files:
      - verilog/dnc_pkg.sv
      - verilog/dnc_write_loader.sv
      - verilog/dnc_row_update.sv
      - verilog/dnc_memory_drain.sv
      - verilog/dnc_memory_matrix.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/dnc_memory_matrix_tb.sv

//--- verif/dnc_tb_model.svh
// Reference model for the memory write stage: data types, update rule, random fill, expected matrix
`ifndef DNC_TB_MODEL_SVH
`define DNC_TB_MODEL_SVH

`default_nettype none

//////////////////////////////////////////////////
// Model data types
//////////////////////////////////////////////////

typedef dnc_pkg::mem_word_t matrix_t   [dnc_pkg::n_rows][dnc_pkg::w_cols];
typedef dnc_pkg::frac_t     row_frac_t [dnc_pkg::n_rows];
typedef dnc_pkg::frac_t     col_frac_t [dnc_pkg::w_cols];
typedef dnc_pkg::mem_word_t col_word_t [dnc_pkg::w_cols];

// New word from old word, weighting, erase and write value
// Fractions scale by 256, each product cut right after its multiply
function automatic dnc_pkg::mem_word_t expected_word(input int unsigned old_word,
                                                     input int unsigned weight,
                                                     input int unsigned erase,
                                                     input int unsigned value);
  int unsigned erase_prod;
  int unsigned kept;
  int unsigned added;
  erase_prod = (weight * erase) >> 8;
  kept       = (old_word * (256 - erase_prod)) >> 8;
  added      = (weight * value) >> 8;
  // Wraps at 16 bits
  return dnc_pkg::mem_word_t'((kept + added) & 32'h0000_ffff);
endfunction

// Random old matrix
task automatic fill_matrix(inout integer seed, output matrix_t m);
  for (int j = 0; j < dnc_pkg::n_rows; j++) begin
    for (int k = 0; k < dnc_pkg::w_cols; k++) begin
      m[j][k] = dnc_pkg::mem_word_t'($random(seed));
    end
  end
endtask

// Random weighting, erase and write vectors
task automatic fill_vectors(inout integer seed, output row_frac_t w,
                            output col_frac_t e, output col_word_t v);
  for (int j = 0; j < dnc_pkg::n_rows; j++) begin
    w[j] = dnc_pkg::frac_t'($random(seed));
  end
  for (int k = 0; k < dnc_pkg::w_cols; k++) begin
    e[k] = dnc_pkg::frac_t'($random(seed));
    v[k] = dnc_pkg::mem_word_t'($random(seed));
  end
endtask

// Whole expected output matrix
task automatic build_expected(input matrix_t m, input row_frac_t w, input col_frac_t e,
                              input col_word_t v, output matrix_t x);
  for (int j = 0; j < dnc_pkg::n_rows; j++) begin
    for (int k = 0; k < dnc_pkg::w_cols; k++) begin
      x[j][k] = expected_word(m[j][k], w[j], e[k], v[k]);
    end
  end
endtask

`default_nettype wire

`endif

//--- verif/dnc_memory_matrix_tb.sv
// Memory write stage testbench with clock, reset, stimulus, output capture and checks
`include "dnc_tb_model.svh"
`default_nettype none

module dnc_memory_matrix_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int total = dnc_pkg::n_rows * dnc_pkg::w_cols;

  logic               CLK;
  logic               RST;
  logic               START;
  logic               READY;
  logic               M_IN_J_ENABLE;
  logic               M_IN_K_ENABLE;
  logic               W_IN_J_ENABLE;
  logic               V_IN_K_ENABLE;
  logic               E_IN_K_ENABLE;
  dnc_pkg::mem_word_t M_IN;
  dnc_pkg::mem_word_t V_IN;
  dnc_pkg::frac_t     W_IN;
  dnc_pkg::frac_t     E_IN;
  dnc_pkg::mem_word_t M_OUT;
  logic               M_OUT_J_ENABLE;
  logic               M_OUT_K_ENABLE;

  // Test data and results
  matrix_t   old_mat;
  matrix_t   exp_mat;
  matrix_t   got_mat;
  row_frac_t w_vec;
  col_frac_t e_vec;
  col_word_t v_vec;

  integer seed;
  string  test_name;
  logic   in_run;
  // Capture state for one run
  int     k_count;
  int     ready_count;
  int     cap_j;
  int     cap_k;
  logic   prev_final;

  dnc_memory_matrix dnc_memory_matrix_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .M_IN_J_ENABLE  (M_IN_J_ENABLE),
    .M_IN_K_ENABLE  (M_IN_K_ENABLE),
    .W_IN_J_ENABLE  (W_IN_J_ENABLE),
    .V_IN_K_ENABLE  (V_IN_K_ENABLE),
    .E_IN_K_ENABLE  (E_IN_K_ENABLE),
    .M_IN           (M_IN),
    .V_IN           (V_IN),
    .W_IN           (W_IN),
    .E_IN           (E_IN),
    .M_OUT          (M_OUT),
    .M_OUT_J_ENABLE (M_OUT_J_ENABLE),
    .M_OUT_K_ENABLE (M_OUT_K_ENABLE)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  task automatic fail_run(input string msg);
    $display("STATUS: FAIL");
    $display("%s", msg);
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Next drive point just after the rising edge
  task automatic tick();
    @(posedge CLK);
    #5;
  endtask

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // READY right after an element and never two cycles long
  assert property (@(posedge CLK) disable iff (RST) READY |-> $past(M_OUT_K_ENABLE))
    else fail_run("READY rose without an output element in the cycle before");
  assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else fail_run("READY stayed high for more than one cycle");

  // Capture on the falling edge mid-cycle
  always @(negedge CLK) begin
    if (!in_run) begin
      assert (!READY && !M_OUT_J_ENABLE && !M_OUT_K_ENABLE)
        else fail_run($sformatf("READY or an output strobe went high while idle at %s",
                                test_name));
    end else begin
      if (READY) begin
        ready_count++;
        assert (prev_final)
          else fail_run($sformatf("READY in %s did not follow the last element", test_name));
      end
      if (M_OUT_K_ENABLE) begin
        assert (k_count < total)
          else fail_run($sformatf("More output elements than the matrix holds in %s",
                                  test_name));
        assert (M_OUT_J_ENABLE == (cap_k == 0))
          else fail_run($sformatf("Mismatch %s J strobe at element %0d: expected %0b, actual %0b",
                                  test_name, k_count, (cap_k == 0), M_OUT_J_ENABLE));
        got_mat[cap_j][cap_k] = M_OUT;
        k_count++;
        if (cap_k == dnc_pkg::w_cols - 1) begin
          cap_k = 0;
          cap_j++;
        end else begin
          cap_k++;
        end
      end else begin
        assert (!M_OUT_J_ENABLE)
          else fail_run($sformatf("Row strobe without an element strobe in %s", test_name));
      end
      prev_final = M_OUT_K_ENABLE && (k_count == total);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Random strobes and data while the DUT is idle
  task automatic drive_idle_strobes();
    for (int i = 0; i < 6; i++) begin
      tick();
      M_IN_J_ENABLE = 1'($random(seed));
      M_IN_K_ENABLE = 1'($random(seed));
      W_IN_J_ENABLE = 1'($random(seed));
      E_IN_K_ENABLE = 1'($random(seed));
      V_IN_K_ENABLE = 1'($random(seed));
      M_IN          = dnc_pkg::mem_word_t'($random(seed));
      V_IN          = dnc_pkg::mem_word_t'($random(seed));
      W_IN          = dnc_pkg::frac_t'($random(seed));
      E_IN          = dnc_pkg::frac_t'($random(seed));
    end
    tick();
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    E_IN_K_ENABLE = 1'b0;
    V_IN_K_ENABLE = 1'b0;
  endtask

  // One cycle of erase/write strobes for column k
  task automatic drive_ev(input logic e_on, input logic v_on, input int k);
    tick();
    E_IN_K_ENABLE = e_on;
    V_IN_K_ENABLE = v_on;
    E_IN          = e_vec[k];
    V_IN          = v_vec[k];
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (ready_count == 0) begin
      @(posedge CLK);
      n++;
      if (n > limit) begin
        fail_run($sformatf("Timeout waiting for READY in %s", test_name));
      end
    end
  endtask

  // Full run with load, update, drain and compare
  task automatic run_case(input string name, input logic split_cols, input logic idle_noise);
    test_name = name;
    if (idle_noise) begin
      drive_idle_strobes();
    end
    build_expected(old_mat, w_vec, e_vec, v_vec, exp_mat);
    k_count     = 0;
    ready_count = 0;
    cap_j       = 0;
    cap_k       = 0;
    prev_final  = 1'b0;
    tick();
    in_run = 1'b1;
    START  = 1'b1;
    tick();
    START = 1'b0;
    // Old matrix, row by row
    for (int j = 0; j < dnc_pkg::n_rows; j++) begin
      for (int k = 0; k < dnc_pkg::w_cols; k++) begin
        if (j != 0 || k != 0) begin
          tick();
        end
        M_IN_K_ENABLE = 1'b1;
        M_IN_J_ENABLE = (k == 0);
        M_IN          = old_mat[j][k];
      end
    end
    tick();
    M_IN_K_ENABLE = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    // Write weighting
    for (int j = 0; j < dnc_pkg::n_rows; j++) begin
      tick();
      W_IN_J_ENABLE = 1'b1;
      W_IN          = w_vec[j];
    end
    tick();
    W_IN_J_ENABLE = 1'b0;
    // Erase and write columns
    for (int k = 0; k < dnc_pkg::w_cols; k++) begin
      if (!split_cols) begin
        drive_ev(1'b1, 1'b1, k);
      end else if (k % 2 == 0) begin
        // Write value first
        drive_ev(1'b0, 1'b1, k);
        drive_ev(1'b0, 1'b0, k);
        drive_ev(1'b1, 1'b0, k);
      end else begin
        drive_ev(1'b1, 1'b0, k);
        drive_ev(1'b0, 1'b0, k);
        drive_ev(1'b0, 1'b0, k);
        drive_ev(1'b0, 1'b1, k);
      end
    end
    drive_ev(1'b0, 1'b0, 0);
    wait_ready(200);
    // A few quiet cycles to catch a second READY
    repeat (3) @(posedge CLK);
    assert (ready_count == 1)
      else fail_run($sformatf("Mismatch %s READY pulses: expected 1, actual %0d",
                              name, ready_count));
    assert (k_count == total)
      else fail_run($sformatf("Mismatch %s element count: expected %0d, actual %0d",
                              name, total, k_count));
    for (int j = 0; j < dnc_pkg::n_rows; j++) begin
      for (int k = 0; k < dnc_pkg::w_cols; k++) begin
        assert (got_mat[j][k] === exp_mat[j][k])
          else fail_run($sformatf("Mismatch %s M(%0d,%0d): expected %h, actual %h",
                                  name, j, k, exp_mat[j][k], got_mat[j][k]));
      end
    end
    tick();
    in_run = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed          = 32'h8b61;
    CLK           = 1'b0;
    RST           = 1'b1;
    START         = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    V_IN_K_ENABLE = 1'b0;
    E_IN_K_ENABLE = 1'b0;
    M_IN          = '0;
    V_IN          = '0;
    W_IN          = '0;
    E_IN          = '0;
    in_run        = 1'b0;
    test_name     = "reset_state";
    repeat (4) @(posedge CLK);
    #5;
    RST = 1'b0;
    repeat (3) tick();

    fill_matrix(seed, old_mat);
    fill_vectors(seed, w_vec, e_vec, v_vec);
    run_case("random_update", 1'b0, 1'b0);

    // Zero weighting leaves the matrix as it was
    fill_matrix(seed, old_mat);
    fill_vectors(seed, w_vec, e_vec, v_vec);
    for (int j = 0; j < dnc_pkg::n_rows; j++) begin
      w_vec[j] = '0;
    end
    run_case("zero_weight", 1'b0, 1'b0);

    // Largest weighting and erase
    fill_matrix(seed, old_mat);
    fill_vectors(seed, w_vec, e_vec, v_vec);
    for (int j = 0; j < dnc_pkg::n_rows; j++) begin
      w_vec[j] = 8'hff;
    end
    for (int k = 0; k < dnc_pkg::w_cols; k++) begin
      e_vec[k] = 8'hff;
    end
    run_case("full_erase", 1'b0, 1'b0);

    fill_matrix(seed, old_mat);
    fill_vectors(seed, w_vec, e_vec, v_vec);
    run_case("column_pairing", 1'b1, 1'b0);

    fill_matrix(seed, old_mat);
    fill_vectors(seed, w_vec, e_vec, v_vec);
    run_case("idle_strobes", 1'b0, 1'b1);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/dnc_memory_matrix.sv
// Memory write stage top with run sequencer, loader, row lanes and output drain
`default_nettype none

module dnc_memory_matrix (
  input  logic               CLK,
  input  logic               RST,
  input  logic               START,
  output logic               READY,
  input  logic               M_IN_J_ENABLE,
  input  logic               M_IN_K_ENABLE,
  input  logic               W_IN_J_ENABLE,
  input  logic               V_IN_K_ENABLE,
  input  logic               E_IN_K_ENABLE,
  input  dnc_pkg::mem_word_t M_IN,
  input  dnc_pkg::mem_word_t V_IN,
  input  dnc_pkg::frac_t     W_IN,
  input  dnc_pkg::frac_t     E_IN,
  output dnc_pkg::mem_word_t M_OUT,
  output logic               M_OUT_J_ENABLE,
  output logic               M_OUT_K_ENABLE
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_settle,
    st_drain
  } seq_state_t;

  seq_state_t state;
  // Second settle cycle
  logic       settle_cnt;

  logic active;
  logic go;
  logic drain_done;

  // Loader outputs
  dnc_pkg::mem_load_t                   mem_load;
  dnc_pkg::frac_t [dnc_pkg::n_rows-1:0] weights;
  dnc_pkg::col_op_t                     col_op;
  logic                                 last_col;

  // Lane read path
  dnc_pkg::col_idx_t                        rd_col;
  dnc_pkg::mem_word_t [dnc_pkg::n_rows-1:0] rows_rd;

  //////////////////////////////////////////////////
  // Run sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= st_idle;
      settle_cnt <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (START) begin
            state <= st_busy;
          end
        end
        st_busy: begin
          settle_cnt <= 1'b0;
          if (last_col) begin
            state <= st_settle;
          end
        end
        st_settle: begin
          // Two cycles for the lane pipeline to empty
          settle_cnt <= 1'b1;
          if (settle_cnt) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          if (drain_done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Inputs only accepted while busy
  assign active = (state == st_busy);
  assign go     = (state == st_settle) && settle_cnt;
  assign READY  = drain_done;

  //////////////////////////////////////////////////
  // Loader, lanes and drain
  //////////////////////////////////////////////////

  dnc_write_loader loader_inst (
    .CLK        (CLK),
    .RST        (RST),
    .active     (active),
    .m_j_strobe (M_IN_J_ENABLE),
    .m_k_strobe (M_IN_K_ENABLE),
    .w_strobe   (W_IN_J_ENABLE),
    .e_strobe   (E_IN_K_ENABLE),
    .v_strobe   (V_IN_K_ENABLE),
    .m_in       (M_IN),
    .v_in       (V_IN),
    .w_in       (W_IN),
    .e_in       (E_IN),
    .mem_load   (mem_load),
    .weights    (weights),
    .col_op     (col_op),
    .last_col   (last_col)
  );

  // One lane per matrix row
  for (genvar j = 0; j < dnc_pkg::n_rows; j++) begin : g_lane
    dnc_row_update lane_inst (
      .CLK      (CLK),
      .RST      (RST),
      .row      (dnc_pkg::row_idx_t'(j)),
      .mem_load (mem_load),
      .weight   (weights[j]),
      .col_op   (col_op),
      .rd_col   (rd_col),
      .rd_word  (rows_rd[j])
    );
  end

  dnc_memory_drain drain_inst (
    .CLK      (CLK),
    .RST      (RST),
    .go       (go),
    .rows     (rows_rd),
    .rd_col   (rd_col),
    .m_out    (M_OUT),
    .j_strobe (M_OUT_J_ENABLE),
    .k_strobe (M_OUT_K_ENABLE),
    .done     (drain_done)
  );

endmodule

`default_nettype wire

//--- verilog/dnc_memory_drain.sv
// Output drain walking the lanes in row-major order with output strobes
`default_nettype none

module dnc_memory_drain (
  input  logic                                     CLK,
  input  logic                                     RST,
  input  logic                                     go,
  input  dnc_pkg::mem_word_t [dnc_pkg::n_rows-1:0] rows,
  output dnc_pkg::col_idx_t                        rd_col,
  output dnc_pkg::mem_word_t                       m_out,
  output logic                                     j_strobe,
  output logic                                     k_strobe,
  output logic                                     done
);

  // Walk position
  dnc_pkg::row_idx_t j_cnt;
  dnc_pkg::col_idx_t k_cnt;

  logic running;
  logic emit;
  logic at_last;
  // High with the final element
  logic last_q;

  assign emit    = go || running;
  assign at_last = (j_cnt == dnc_pkg::row_max) && (k_cnt == dnc_pkg::col_max);

  // All lanes read the same column
  assign rd_col = k_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      j_cnt    <= '0;
      k_cnt    <= '0;
      running  <= 1'b0;
      m_out    <= '0;
      j_strobe <= 1'b0;
      k_strobe <= 1'b0;
      last_q   <= 1'b0;
      done     <= 1'b0;
    end else begin
      j_strobe <= 1'b0;
      k_strobe <= 1'b0;
      last_q   <= emit && at_last;
      // Ready pulse trails the last element
      done     <= last_q;
      if (emit) begin
        m_out    <= rows[j_cnt];
        k_strobe <= 1'b1;
        // J marks each row's first element
        j_strobe <= (k_cnt == '0);
        if (at_last) begin
          running <= 1'b0;
          j_cnt   <= '0;
          k_cnt   <= '0;
        end else begin
          running <= 1'b1;
          if (k_cnt == dnc_pkg::col_max) begin
            k_cnt <= '0;
            j_cnt <= j_cnt + 1'b1;
          end else begin
            k_cnt <= k_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dnc_row_update.sv
// Row update lane with one-stage erase/write pipeline and column read port
`default_nettype none

module dnc_row_update (
  input  logic               CLK,
  input  logic               RST,
  input  dnc_pkg::row_idx_t  row,
  input  dnc_pkg::mem_load_t mem_load,
  input  dnc_pkg::frac_t     weight,
  input  dnc_pkg::col_op_t   col_op,
  input  dnc_pkg::col_idx_t  rd_col,
  output dnc_pkg::mem_word_t rd_word
);

  //////////////////////////////////////////////////
  // Row storage and pipeline stage
  //////////////////////////////////////////////////

  // One word per column
  dnc_pkg::mem_word_t words [dnc_pkg::w_cols];

  // Column op in flight
  dnc_pkg::col_op_t   op_q;
  // Old word captured alongside it
  dnc_pkg::mem_word_t old_q;

  logic load_hit;

  // Broadcast load, only this row
  assign load_hit = mem_load.valid && (mem_load.row == row);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_q <= '0;
    end else begin
      op_q <= col_op;
    end
  end

  // Read old word in the op's own cycle
  always_ff @(posedge CLK) begin
    if (col_op.valid) begin
      old_q <= words[col_op.col];
    end
  end

  //////////////////////////////////////////////////
  // Word update
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < dnc_pkg::w_cols; k++) begin
        words[k] <= '0;
      end
    end else begin
      // Stage result lands one cycle after the op
      if (op_q.valid) begin
        words[op_q.col] <= dnc_pkg::dnc_update(old_q, weight, op_q.erase, op_q.value);
      end
      // Initial matrix element
      if (load_hit) begin
        words[mem_load.col] <= mem_load.word;
      end
    end
  end

  // Drain read port
  assign rd_word = words[rd_col];

endmodule

`default_nettype wire

//--- verilog/dnc_write_loader.sv
// Input loader turning matrix, weighting and erase/write strobes into lane operations
`default_nettype none

module dnc_write_loader (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    active,
  input  logic                                    m_j_strobe,
  input  logic                                    m_k_strobe,
  input  logic                                    w_strobe,
  input  logic                                    e_strobe,
  input  logic                                    v_strobe,
  input  dnc_pkg::mem_word_t                      m_in,
  input  dnc_pkg::mem_word_t                      v_in,
  input  dnc_pkg::frac_t                          w_in,
  input  dnc_pkg::frac_t                          e_in,
  output dnc_pkg::mem_load_t                      mem_load,
  output dnc_pkg::frac_t [dnc_pkg::n_rows-1:0]    weights,
  output dnc_pkg::col_op_t                        col_op,
  output logic                                    last_col
);

  // Matrix phase position
  dnc_pkg::row_idx_t m_row;
  dnc_pkg::col_idx_t m_col;
  dnc_pkg::row_idx_t ld_row;
  dnc_pkg::col_idx_t ld_col;

  // Weighting position
  dnc_pkg::row_idx_t w_cnt;

  // Erase and write columns, counted apart
  dnc_pkg::col_idx_t e_col;
  dnc_pkg::col_idx_t v_col;
  dnc_pkg::col_idx_t op_col;

  // One-slot holding for the early half of a column
  dnc_pkg::frac_t     e_hold;
  dnc_pkg::mem_word_t v_hold;
  logic               e_full;
  logic               v_full;

  logic m_take;
  logic w_take;
  logic e_take;
  logic v_take;
  logic col_done;

  //////////////////////////////////////////////////
  // Strobe qualification
  //////////////////////////////////////////////////

  always_comb begin
    m_take   = active && m_k_strobe;
    w_take   = active && w_strobe;
    e_take   = active && e_strobe;
    v_take   = active && v_strobe;
    // Row start realigns the column
    ld_col   = m_j_strobe ? '0 : m_col;
    ld_row   = (m_j_strobe && m_col != '0) ? m_row + 1'b1 : m_row;
    // Column complete once both halves present
    col_done = (e_full || e_take) && (v_full || v_take);
    // Whichever side arrives now names the column
    op_col   = e_take ? e_col : v_col;
  end

  //////////////////////////////////////////////////
  // Counters and pairing flags
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m_row  <= '0;
      m_col  <= '0;
      w_cnt  <= '0;
      e_col  <= '0;
      v_col  <= '0;
      e_full <= 1'b0;
      v_full <= 1'b0;
    end else if (!active) begin
      // Cleared between runs
      m_row  <= '0;
      m_col  <= '0;
      w_cnt  <= '0;
      e_col  <= '0;
      v_col  <= '0;
      e_full <= 1'b0;
      v_full <= 1'b0;
    end else begin
      if (m_take) begin
        m_col <= (ld_col == dnc_pkg::col_max) ? '0 : ld_col + 1'b1;
        m_row <= (ld_col == dnc_pkg::col_max) ? ld_row + 1'b1 : ld_row;
      end
      if (w_take) begin
        w_cnt <= w_cnt + 1'b1;
      end
      if (e_take) begin
        e_col <= e_col + 1'b1;
      end
      if (v_take) begin
        v_col <= v_col + 1'b1;
      end
      if (col_done) begin
        e_full <= 1'b0;
        v_full <= 1'b0;
      end else begin
        if (e_take) begin
          e_full <= 1'b1;
        end
        if (v_take) begin
          v_full <= 1'b1;
        end
      end
    end
  end

  // Held values and weighting table
  always_ff @(posedge CLK) begin
    if (e_take) begin
      e_hold <= e_in;
    end
    if (v_take) begin
      v_hold <= v_in;
    end
    if (w_take) begin
      weights[w_cnt] <= w_in;
    end
  end

  //////////////////////////////////////////////////
  // Registered lane operations
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mem_load <= '0;
      col_op   <= '0;
      last_col <= 1'b0;
    end else begin
      mem_load.valid <= m_take;
      mem_load.row   <= ld_row;
      mem_load.col   <= ld_col;
      mem_load.word  <= m_in;
      col_op.valid   <= col_done;
      col_op.col     <= op_col;
      col_op.erase   <= e_take ? e_in : e_hold;
      col_op.value   <= v_take ? v_in : v_hold;
      // Flags the final column op
      last_col       <= col_done && (op_col == dnc_pkg::col_max);
    end
  end

endmodule

`default_nettype wire

//--- verilog/dnc_pkg.sv
// Matrix sizes, number formats, load and column-op structs, element update function
`default_nettype none

package dnc_pkg;

  //////////////////////////////////////////////////
  // Sizes and formats
  //////////////////////////////////////////////////

  // Memory rows N and columns W
  localparam int unsigned n_rows = 4;
  localparam int unsigned w_cols = 8;

  // Word and fraction widths
  localparam int unsigned data_w = 16;
  localparam int unsigned frac_w = 8;

  // Fraction scale, a value x means x/256
  localparam int unsigned frac_one = 1 << frac_w;

  typedef logic [$clog2(n_rows)-1:0] row_idx_t;
  typedef logic [$clog2(w_cols)-1:0] col_idx_t;
  typedef logic [data_w-1:0]         mem_word_t;
  typedef logic [frac_w-1:0]         frac_t;

  // Final row and column index
  localparam row_idx_t row_max = row_idx_t'(n_rows - 1);
  localparam col_idx_t col_max = col_idx_t'(w_cols - 1);

  //////////////////////////////////////////////////
  // Lane payloads
  //////////////////////////////////////////////////

  // One initial matrix element
  typedef struct packed {
    logic      valid;
    row_idx_t  row;
    col_idx_t  col;
    mem_word_t word;
  } mem_load_t;

  // One column of erase and write values
  typedef struct packed {
    logic      valid;
    col_idx_t  col;
    frac_t     erase;
    mem_word_t value;
  } col_op_t;

  // M(j,k) = M(j,k)*(1 - w(j)*e(k)) + w(j)*v(k)
  // Each product truncated right after its multiply
  function automatic mem_word_t dnc_update(input mem_word_t old_word,
                                           input frac_t     weight,
                                           input frac_t     erase,
                                           input mem_word_t value);
    logic [2*frac_w-1:0]      erase_full;
    frac_t                    erase_prod;
    logic [frac_w:0]          keep;
    logic [data_w+frac_w:0]   kept_full;
    logic [data_w+frac_w-1:0] added_full;
    mem_word_t                kept;
    mem_word_t                added;
    erase_full = weight * erase;
    erase_prod = erase_full[2*frac_w-1:frac_w];
    // Keep factor 1 - w*e, at most 256
    keep       = (frac_w + 1)'(frac_one) - {1'b0, erase_prod};
    kept_full  = old_word * keep;
    kept       = kept_full[data_w+frac_w-1:frac_w];
    added_full = weight * value;
    added      = added_full[data_w+frac_w-1:frac_w];
    // Sum wraps at 16 bits
    return kept + added;
  endfunction

endpackage

`default_nettype wire
